// ==== design/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ROB sizing, one tag per entry
`define ROB_DEPTH 16
`define TAG_W     4

// Store buffer sizing
`define SB_DEPTH  8
`define SB_IDX_W  3

`define XLEN      32  // Data and address width
`define RETIRE_W  2   // Max entries retired per cycle

`endif

// ==== design/rob_pkg.sv ====
`include "core_macros.svh"

// Types seen by the reorder buffer and its retire channel
package rob_pkg;

    typedef logic [`TAG_W-1:0] tag_t;      // ROB entry number
    typedef logic [4:0]        reg_idx_t;  // Architectural destination

    // Result report from one execution unit
    typedef struct packed {
        logic             valid;
        tag_t             tag;
        logic [`XLEN-1:0] data;  // Result, or store data
        logic [`XLEN-1:0] addr;  // Store address, unused otherwise
    } finish_t;

    // One entry leaving the ROB
    typedef struct packed {
        reg_idx_t         rd;
        logic [`XLEN-1:0] data;
        logic [`XLEN-1:0] addr;
        logic             is_store;
    } retire_t;

endpackage

// ==== design/lsu_pkg.sv ====
`include "core_macros.svh"

// Types for the store buffer side
package lsu_pkg;

    typedef logic [`SB_IDX_W-1:0] slot_t;      // Store buffer slot index
    typedef logic [`SB_IDX_W:0]   free_cnt_t;  // 0 up to SB_DEPTH free slots

    // Buffered store waiting for cache completion
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } store_entry_t;

endpackage

// ==== design/retire_if.sv ====
`timescale 1ns/1ps

// Retirement channel, ROB stage into store buffer stage
interface retire_if;

    logic               valid_0;     // Oldest retiring entry
    logic               valid_1;     // Younger entry, never without valid_0
    rob_pkg::retire_t   entry_0;
    rob_pkg::retire_t   entry_1;
    lsu_pkg::free_cnt_t free_slots;  // Empty slots minus store in flight

    // ROB drives the retired pair and watches the free count
    modport rob_side (
        output valid_0, valid_1, entry_0, entry_1,
        input  free_slots
    );

    // Store buffer takes the store and reports space back
    modport sb_side (
        input  valid_0, valid_1, entry_0, entry_1,
        output free_slots
    );

endinterface

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc,        // Allocate one entry at tail
    input  rob_pkg::reg_idx_t alloc_rd,
    input  logic              alloc_store,
    input  rob_pkg::finish_t  fin_simple,   // Simple path result
    input  rob_pkg::finish_t  fin_complex,  // Complex path result
    output rob_pkg::tag_t     alloc_tag,
    output logic              rob_full,
    retire_if.rob_side        ret
);

    //////////////////////////////////////////////////
    // Entry state
    //////////////////////////////////////////////////

    rob_pkg::tag_t          head;                  // Oldest entry
    rob_pkg::tag_t          tail;                  // Next free entry
    logic [`ROB_DEPTH-1:0]  busy;                  // Allocated, not yet retired
    logic [`ROB_DEPTH-1:0]  finished;              // Result captured
    rob_pkg::retire_t       rob_mem [`ROB_DEPTH];  // rd and store flag at alloc, rest at finish

    // Retire selection, one lane per retire port
    logic [`RETIRE_W-1:0]   take;
    rob_pkg::tag_t          pick_idx [`RETIRE_W];
    rob_pkg::tag_t          n_ret;                 // Entries leaving this edge

    logic                   alloc_ok;

    assign alloc_tag = tail;
    assign rob_full  = &busy;                      // All 16 entries in use
    assign alloc_ok  = alloc && !rob_full;         // Alloc while full is dropped

    //////////////////////////////////////////////////
    // In-order retire pick from head
    //////////////////////////////////////////////////

    always_comb begin : retire_pick
        logic blocked;
        logic store_seen;
        blocked    = 1'b0;
        store_seen = 1'b0;
        n_ret      = '0;
        for (int k = 0; k < `RETIRE_W; k++) begin
            pick_idx[k] = head + rob_pkg::tag_t'(k);
            take[k]     = 1'b0;
            // Stops at first entry not ready, so no gaps
            if (!blocked && busy[pick_idx[k]] && finished[pick_idx[k]] &&
                (!rob_mem[pick_idx[k]].is_store ||
                 (!store_seen && ret.free_slots != '0))) begin
                take[k]    = 1'b1;
                store_seen = store_seen | rob_mem[pick_idx[k]].is_store;  // One store per cycle
                n_ret      = n_ret + 1'b1;
            end else begin
                blocked = 1'b1;  // Younger entries wait behind this one
            end
        end
    end

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head        <= '0;
            tail        <= '0;
            busy        <= '0;
            finished    <= '0;
            ret.valid_0 <= 1'b0;
            ret.valid_1 <= 1'b0;
        end else begin
            if (alloc_ok) begin
                busy[tail]     <= 1'b1;
                finished[tail] <= 1'b0;  // Fresh entry, result pending
                tail           <= tail + 1'b1;
            end
            // Finish reports may arrive in any order
            if (fin_simple.valid) begin
                finished[fin_simple.tag] <= 1'b1;
            end
            if (fin_complex.valid) begin
                finished[fin_complex.tag] <= 1'b1;
            end
            for (int k = 0; k < `RETIRE_W; k++) begin
                if (take[k]) begin
                    busy[pick_idx[k]] <= 1'b0;
                end
            end
            head        <= head + n_ret;
            ret.valid_0 <= take[0];
            ret.valid_1 <= take[1];
        end
    end

    // Entry payload and retire registers
    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            rob_mem[tail].rd       <= alloc_rd;
            rob_mem[tail].is_store <= alloc_store;
        end
        if (fin_simple.valid) begin
            rob_mem[fin_simple.tag].data <= fin_simple.data;
            rob_mem[fin_simple.tag].addr <= fin_simple.addr;
        end
        if (fin_complex.valid) begin
            rob_mem[fin_complex.tag].data <= fin_complex.data;
            rob_mem[fin_complex.tag].addr <= fin_complex.addr;
        end
        ret.entry_0 <= rob_mem[pick_idx[0]];  // Older of the pair
        ret.entry_1 <= rob_mem[pick_idx[1]];
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Execution units only report on allocated entries
    a_fin_simple_busy : assert property (@(posedge clk) disable iff (!rst_n)
        fin_simple.valid |-> busy[fin_simple.tag]);
    a_fin_complex_busy : assert property (@(posedge clk) disable iff (!rst_n)
        fin_complex.valid |-> busy[fin_complex.tag]);

    // Second retire lane only fires behind the first
    a_retire_order : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ret.valid_1) |-> ret.valid_0);

endmodule

// ==== design/store_buffer.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module store_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    retire_if.sb_side             ret,
    input  logic                  store_finish,    // Cache reports a finished store
    input  logic [`XLEN-1:0]      store_fin_addr,
    output logic                  store_req_valid, // One pulse per buffered store
    output lsu_pkg::store_entry_t store_req,
    output logic                  sb_full
);

    lsu_pkg::store_entry_t sb_mem [`SB_DEPTH];  // Slot contents
    logic [`SB_DEPTH-1:0]  busy;                // Slot waits for cache

    // Incoming store from the retire pair
    logic                  store_in_valid;
    lsu_pkg::store_entry_t store_in;
    logic                  wr_en;

    lsu_pkg::slot_t        free_idx;            // Slot for incoming store
    logic                  free_found;
    lsu_pkg::slot_t        rel_idx;             // Slot freed by cache
    logic                  rel_hit;

    //////////////////////////////////////////////////
    // Store pick and slot search
    //////////////////////////////////////////////////

    // At most one of the two entries is a store
    always_comb begin : incoming_sel
        store_in_valid = 1'b0;
        store_in       = '{addr: ret.entry_0.addr, data: ret.entry_0.data};
        if (ret.valid_0 && ret.entry_0.is_store) begin
            store_in_valid = 1'b1;
        end else if (ret.valid_1 && ret.entry_1.is_store) begin
            store_in_valid = 1'b1;
            store_in       = '{addr: ret.entry_1.addr, data: ret.entry_1.data};
        end
    end

    // Priority search, highest free slot wins
    always_comb begin : free_search
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (!busy[i]) begin
                free_idx   = lsu_pkg::slot_t'(i);
                free_found = 1'b1;
            end
        end
    end

    // Empty slots less the store now on the channel
    always_comb begin : free_count
        lsu_pkg::free_cnt_t empty_cnt;
        empty_cnt = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            empty_cnt = empty_cnt + lsu_pkg::free_cnt_t'(!busy[i]);
        end
        if (!store_in_valid) begin
            ret.free_slots = empty_cnt;
        end else if (empty_cnt != '0) begin
            ret.free_slots = empty_cnt - 1'b1;
        end else begin
            ret.free_slots = '0;
        end
    end

    // Associative match, lowest busy slot wins
    always_comb begin : release_search
        rel_idx = '0;
        rel_hit = 1'b0;
        for (int i = `SB_DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && sb_mem[i].addr == store_fin_addr) begin
                rel_idx = lsu_pkg::slot_t'(i);
                rel_hit = 1'b1;
            end
        end
    end

    assign wr_en   = store_in_valid && free_found;
    assign sb_full = (ret.free_slots == '0);

    //////////////////////////////////////////////////
    // Slot state and cache request
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy            <= '0;
            store_req_valid <= 1'b0;
        end else begin
            store_req_valid <= wr_en;  // Sent once, on the write edge
            if (wr_en) begin
                busy[free_idx] <= 1'b1;
            end
            if (store_finish && rel_hit) begin
                busy[rel_idx] <= 1'b0;  // No match leaves slots alone
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            sb_mem[free_idx] <= store_in;
        end
        store_req <= store_in;
    end

    // ROB saw room for this store on the cycle it retired it
    a_store_room : assert property (@(posedge clk) disable iff (!rst_n)
        store_in_valid |-> free_found && $past(ret.free_slots) != '0);

endmodule

// ==== design/backend_top.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module backend_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc,
    input  logic [4:0]         alloc_rd,
    input  logic               alloc_store,
    input  logic               fin_simple_valid,
    input  logic [`TAG_W-1:0]  fin_simple_tag,
    input  logic [`XLEN-1:0]   fin_simple_data,
    input  logic [`XLEN-1:0]   fin_simple_addr,
    input  logic               fin_complex_valid,
    input  logic [`TAG_W-1:0]  fin_complex_tag,
    input  logic [`XLEN-1:0]   fin_complex_data,
    input  logic [`XLEN-1:0]   fin_complex_addr,
    input  logic               store_finish,
    input  logic [`XLEN-1:0]   store_fin_addr,
    output logic [`TAG_W-1:0]  alloc_tag,
    output logic               rob_full,
    output logic               reg_wr_en_0,
    output logic [4:0]         reg_wr_rd_0,
    output logic [`XLEN-1:0]   reg_wr_data_0,
    output logic               reg_wr_en_1,
    output logic [4:0]         reg_wr_rd_1,
    output logic [`XLEN-1:0]   reg_wr_data_1,
    output logic               store_req_valid,
    output logic [`XLEN-1:0]   store_req_addr,
    output logic [`XLEN-1:0]   store_req_data,
    output logic               sb_full
);

    rob_pkg::finish_t      fin_simple;
    rob_pkg::finish_t      fin_complex;
    lsu_pkg::store_entry_t store_req;

    retire_if ret_bus ();  // ROB stage to store buffer stage

    // Pack execution reports
    assign fin_simple  = '{valid: fin_simple_valid, tag: fin_simple_tag,
                           data: fin_simple_data, addr: fin_simple_addr};
    assign fin_complex = '{valid: fin_complex_valid, tag: fin_complex_tag,
                           data: fin_complex_data, addr: fin_complex_addr};

    reorder_buffer u_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .alloc_store (alloc_store),
        .fin_simple  (fin_simple),
        .fin_complex (fin_complex),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .ret         (ret_bus.rob_side)
    );

    store_buffer u_sb (
        .clk             (clk),
        .rst_n           (rst_n),
        .ret             (ret_bus.sb_side),
        .store_finish    (store_finish),
        .store_fin_addr  (store_fin_addr),
        .store_req_valid (store_req_valid),
        .store_req       (store_req),
        .sb_full         (sb_full)
    );

    // Register update ports, stores excluded
    assign reg_wr_en_0   = ret_bus.valid_0 && !ret_bus.entry_0.is_store;
    assign reg_wr_rd_0   = ret_bus.entry_0.rd;
    assign reg_wr_data_0 = ret_bus.entry_0.data;
    assign reg_wr_en_1   = ret_bus.valid_1 && !ret_bus.entry_1.is_store;
    assign reg_wr_rd_1   = ret_bus.entry_1.rd;
    assign reg_wr_data_1 = ret_bus.entry_1.data;

    assign store_req_addr = store_req.addr;  // Cache request split
    assign store_req_data = store_req.data;

endmodule

// ==== test/tb_backend.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_backend;

    logic                  clk;
    logic                  rst_n;
    logic                  alloc;
    rob_pkg::reg_idx_t     alloc_rd;
    logic                  alloc_store;
    logic                  fin_simple_valid;
    rob_pkg::tag_t         fin_simple_tag;
    logic [`XLEN-1:0]      fin_simple_data;
    logic [`XLEN-1:0]      fin_simple_addr;
    logic                  fin_complex_valid;
    rob_pkg::tag_t         fin_complex_tag;
    logic [`XLEN-1:0]      fin_complex_data;
    logic [`XLEN-1:0]      fin_complex_addr;
    logic                  store_finish;
    logic [`XLEN-1:0]      store_fin_addr;
    rob_pkg::tag_t         alloc_tag;
    logic                  rob_full;
    logic                  reg_wr_en_0;
    rob_pkg::reg_idx_t     reg_wr_rd_0;
    logic [`XLEN-1:0]      reg_wr_data_0;
    logic                  reg_wr_en_1;
    rob_pkg::reg_idx_t     reg_wr_rd_1;
    logic [`XLEN-1:0]      reg_wr_data_1;
    logic                  store_req_valid;
    logic [`XLEN-1:0]      store_req_addr;
    logic [`XLEN-1:0]      store_req_data;
    logic                  sb_full;

    backend_top dut0 (.*);

    // One table row held on the inputs for one cycle
    typedef struct packed {
        logic [2:0]        test;
        logic              alloc;
        logic              st;
        rob_pkg::reg_idx_t rd;
        logic              fs_v;
        rob_pkg::tag_t     fs_tag;
        logic              fc_v;
        rob_pkg::tag_t     fc_tag;
        logic              sf;
        logic [`XLEN-1:0]  sf_addr;
    } step_t;

    step_t                 steps [$];
    string                 test_names [1:5] = '{"tag order and rob_full", "reverse finish",
                                                "store retire", "store buffer fill",
                                                "slot release"};
    logic [31:0]           rng_state = 32'd17;
    int                    errors = 0;
    int                    checks = 0;
    int                    limit = 0;   // Cycle limit set once the table is built
    int                    cycles;

    // Reference model of ROB and store buffer
    rob_pkg::retire_t      m_ent [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] m_busy;
    logic [`ROB_DEPTH-1:0] m_fin;
    rob_pkg::tag_t         m_head;
    rob_pkg::tag_t         m_tail;
    int                    m_cnt;
    logic [`XLEN-1:0]      sb_q [$];    // Addresses now held in slots
    logic [1:0]            exp_v;       // Expected retire lanes on the channel
    rob_pkg::retire_t      exp_ent [2];
    logic                  exp_req_v;
    lsu_pkg::store_entry_t exp_req;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [`XLEN-1:0] store_addr(rob_pkg::tag_t t);
        return 32'h4000_0000 | {t, 4'h0};  // One line per tag
    endfunction

    // Empty slots minus the store now on the channel
    function automatic int free_now();
        int n;
        n = `SB_DEPTH - sb_q.size();
        for (int k = 0; k < `RETIRE_W; k++) begin
            if (exp_v[k] && exp_ent[k].is_store) n--;
        end
        return n;
    endfunction

    task automatic add_step(int test, bit al, bit st, int rd, bit fs, int ts, bit fc, int tc,
                            bit sf = 1'b0, logic [`XLEN-1:0] sfa = '0);
        steps.push_back('{test: 3'(test), alloc: al, st: st, rd: 5'(rd), fs_v: fs,
                          fs_tag: 4'(ts), fc_v: fc, fc_tag: 4'(tc), sf: sf, sf_addr: sfa});
    endtask

    task automatic drive_step(step_t s);
        alloc             <= s.alloc;
        alloc_rd          <= s.rd;
        alloc_store       <= s.st;
        fin_simple_valid  <= s.fs_v;
        fin_simple_tag    <= s.fs_tag;
        fin_simple_data   <= xorshift();
        fin_simple_addr   <= store_addr(s.fs_tag);
        fin_complex_valid <= s.fc_v;
        fin_complex_tag   <= s.fc_tag;
        fin_complex_data  <= xorshift();
        fin_complex_addr  <= store_addr(s.fc_tag);
        store_finish      <= s.sf;
        store_fin_addr    <= s.sf_addr;
    endtask

    //////////////////////////////////////////////////
    // Model of one clock edge with inputs as now driven
    //////////////////////////////////////////////////

    task automatic model_edge();
        int               free_n;
        int               n_ret;
        logic             go;
        logic             st_seen;
        rob_pkg::tag_t    t;
        rob_pkg::retire_t pick [2];
        logic [1:0]       take;
        free_n  = free_now();
        go      = 1'b1;
        st_seen = 1'b0;
        n_ret   = 0;
        for (int k = 0; k < `RETIRE_W; k++) begin
            t       = m_head + rob_pkg::tag_t'(k);
            pick[k] = m_ent[t];
            // Oldest first and a store needs room with only one store per cycle
            go      = go && m_busy[t] && m_fin[t] &&
                      (!m_ent[t].is_store || (!st_seen && free_n > 0));
            take[k] = go;
            if (go) begin
                st_seen   = st_seen | m_ent[t].is_store;
                m_busy[t] = 1'b0;
                n_ret++;
            end
        end
        // Store on the channel goes to a slot and to the cache
        exp_req_v = 1'b0;
        for (int k = 0; k < `RETIRE_W; k++) begin
            if (exp_v[k] && exp_ent[k].is_store) begin
                exp_req_v = 1'b1;
                exp_req   = '{addr: exp_ent[k].addr, data: exp_ent[k].data};
            end
        end
        if (store_finish) begin
            for (int j = 0; j < sb_q.size(); j++) begin
                if (sb_q[j] == store_fin_addr) begin
                    sb_q.delete(j);  // One slot per completion
                    break;
                end
            end
        end
        if (exp_req_v) sb_q.push_back(exp_req.addr);
        if (alloc && m_cnt < `ROB_DEPTH) begin
            m_busy[m_tail]         = 1'b1;
            m_fin[m_tail]          = 1'b0;
            m_ent[m_tail].rd       = alloc_rd;
            m_ent[m_tail].is_store = alloc_store;
            m_tail++;
            m_cnt++;
        end
        if (fin_simple_valid) begin
            m_fin[fin_simple_tag]      = 1'b1;
            m_ent[fin_simple_tag].data = fin_simple_data;
            m_ent[fin_simple_tag].addr = fin_simple_addr;
        end
        if (fin_complex_valid) begin
            m_fin[fin_complex_tag]      = 1'b1;
            m_ent[fin_complex_tag].data = fin_complex_data;
            m_ent[fin_complex_tag].addr = fin_complex_addr;
        end
        m_head  = m_head + rob_pkg::tag_t'(n_ret);
        m_cnt   = m_cnt - n_ret;
        exp_v   = take;
        exp_ent = pick;
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_reg_update(int lane, logic en, rob_pkg::reg_idx_t rd,
                                    logic [`XLEN-1:0] data);
        logic exp_en;
        exp_en = exp_v[lane] && !exp_ent[lane].is_store;  // Stores never write a register
        checks++;
        if (en !== exp_en ||
            (exp_en && (rd !== exp_ent[lane].rd || data !== exp_ent[lane].data))) begin
            errors++;
            $display("Mismatch at %0t: reg port %0d en %b rd %0d data %h, expected %b %0d %h",
                     $time, lane, en, rd, data, exp_en, exp_ent[lane].rd, exp_ent[lane].data);
        end
    endtask

    task automatic check_store_req(logic valid, lsu_pkg::store_entry_t req);
        checks++;
        if (valid !== exp_req_v || (exp_req_v && req !== exp_req)) begin
            errors++;
            $display("Mismatch at %0t: store req %b %h/%h, expected %b %h/%h", $time, valid,
                     req.addr, req.data, exp_req_v, exp_req.addr, exp_req.data);
        end
    endtask

    task automatic check_flags(rob_pkg::tag_t tag, logic full, logic sfull);
        checks++;
        if (tag !== m_tail || full !== (m_cnt == `ROB_DEPTH) || sfull !== (free_now() <= 0)) begin
            errors++;
            $display("Mismatch at %0t: alloc_tag %0d rob_full %b sb_full %b, expected %0d %b %b",
                     $time, tag, full, sfull, m_tail, m_cnt == `ROB_DEPTH, free_now() <= 0);
        end
    endtask

    initial begin
        int err_mark;
        drive_step('0);
        rst_n = 1'b0;
        // Test 1 allocates sixteen entries then one more while full
        for (int i = 0; i < 17; i++) add_step(1, 1, 0, i + 1, 0, 0, 0, 0);
        // Test 2 finishes 15 down to 0 on alternating units then drains
        for (int i = 15; i >= 0; i--) add_step(2, 0, 0, 0, i % 2, i, !(i % 2), i);
        repeat (9) add_step(2, 0, 0, 0, 0, 0, 0, 0);
        // Test 3 retires an ALU op and a store together and completes the store
        add_step(3, 1, 0, 3, 0, 0, 0, 0);
        add_step(3, 1, 1, 4, 0, 0, 0, 0);
        add_step(3, 0, 0, 0, 1, 1, 1, 0);
        repeat (3) add_step(3, 0, 0, 0, 0, 0, 0, 0);
        add_step(3, 0, 0, 0, 0, 0, 0, 0, 1, store_addr(1));
        add_step(3, 0, 0, 0, 0, 0, 0, 0);
        // Test 4 has nine stores and one ALU op each finished a cycle after alloc
        for (int i = 0; i < 11; i++) add_step(4, i < 10, i < 9, 10 + i, i > 0, 1 + i, 0, 0);
        repeat (8) add_step(4, 0, 0, 0, 0, 0, 0, 0);
        // Test 5 sends a miss first and then a hit on the tag 2 store
        add_step(5, 0, 0, 0, 0, 0, 0, 0, 1, store_addr(2) | 32'h8);
        repeat (2) add_step(5, 0, 0, 0, 0, 0, 0, 0);
        add_step(5, 0, 0, 0, 0, 0, 0, 0, 1, store_addr(2));
        repeat (5) add_step(5, 0, 0, 0, 0, 0, 0, 0);
        limit     = steps.size() * 4 + 50;
        m_busy    = '0;
        m_fin     = '0;
        m_head    = '0;
        m_tail    = '0;
        m_cnt     = 0;
        exp_v     = '0;
        exp_req_v = 1'b0;
        err_mark  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i <= steps.size(); i++) begin
            @(posedge clk);
            drive_step(i < steps.size() ? steps[i] : step_t'('0));
            @(negedge clk);
            check_reg_update(0, reg_wr_en_0, reg_wr_rd_0, reg_wr_data_0);
            check_reg_update(1, reg_wr_en_1, reg_wr_rd_1, reg_wr_data_1);
            check_store_req(store_req_valid, '{addr: store_req_addr, data: store_req_data});
            check_flags(alloc_tag, rob_full, sb_full);
            // Checks here cover the step before so a test ends one cycle late
            if (i > 0 && (i == steps.size() || steps[i].test != steps[i - 1].test)) begin
                $display("test %0d (%s): %0d errors", steps[i - 1].test,
                         test_names[steps[i - 1].test], errors - err_mark);
                err_mark = errors;
            end
            model_edge();
        end
        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog on total cycles
    initial begin
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not end within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/rob_pkg.sv
design/lsu_pkg.sv
design/retire_if.sv
design/reorder_buffer.sv
design/store_buffer.sv
design/backend_top.sv
test/tb_backend.sv

// ==== Bender.yml ====
package:
  name: backend_core

export_include_dirs:
  - design

sources:
  - design/rob_pkg.sv
  - design/lsu_pkg.sv
  - design/retire_if.sv
  - design/reorder_buffer.sv
  - design/store_buffer.sv
  - design/backend_top.sv
  - target: simulation
    files:
      - test/tb_backend.sv
